/* Makefile */
# Verilator flow for the feature-map memory interface testbench

TOP := pool_mif_tb
OBJ := obj_dir

.PHONY: all compile run clean

all: run

# Build the simulation binary from the file list
compile:
	verilator --binary --timing -Wno-fatal -f pool_mif.f --top-module $(TOP) -Mdir $(OBJ) -o V$(TOP)

# Run and decide pass or fail from the log
run: compile
	./$(OBJ)/V$(TOP) | tee sim.log
	@if grep -q "^Testbench passed$$" sim.log; then \
		echo "Simulation PASS"; \
	else \
		echo "Simulation FAIL"; \
		exit 1; \
	fi

clean:
	rm -rf $(OBJ) sim.log

/* dv/pool_mif_checker.sv */
/*
 * Scoreboard for the pooling stream and for the FIFO level seen from the ports.
 * Tracks one job at a time. The testbench announces each job before its start.
 */

`timescale 1ns/1ps

module pool_mif_checker #(
    parameter int FIFO_ADDR_WIDTH = 6
) (
    input  logic                 clk,
    input  logic                 rst_n,
    input  logic                 glb_fm_valid,
    input  logic                 glb_fm_ready,
    input  logic                 pool_fm_valid,
    input  mif_types_pkg::fmap_t pool_fm,
    input  logic                 pool_fm_ready
);

    import mif_types_pkg::*;

    localparam int DEPTH = 1 << FIFO_ADDR_WIDTH;

    // Current job
    string     test_name  = "none";
    glb_addr_t exp_base   = '0;
    word_cnt_t exp_stride = '0;
    word_cnt_t exp_count  = '0;
    word_cnt_t got        = '0;
    logic      job_open   = 1'b0;

    // Words between the two channels, i.e. the FIFO level
    int        fill         = 0;
    int        max_fill     = 0;
    int        mismatch_cnt = 0;
    int        fail_cnt     = 0;

    glb_addr_t exp_addr;
    fmap_t     exp_word;

    // ======================================================================
    // Reference content of the global buffer
    // ======================================================================

    // XOR with a fixed pattern, then rotate left by 7
    function automatic fmap_t glb_word(input glb_addr_t addr);
        fmap_t w;
        w = {16'h0000, addr} ^ 32'hC3A5_5A3C;
        return {w[24:0], w[31:25]};
    endfunction

    task automatic start_job(input string name, input glb_addr_t base,
                             input word_cnt_t stride, input word_cnt_t count);
        test_name  = name;
        exp_base   = base;
        exp_stride = stride;
        exp_count  = count;
        got        = '0;
        job_open   = 1'b1;
        max_fill   = 0;
    endtask

    task automatic end_job();
        if (got !== exp_count) begin
            $display("MISMATCH %s word count: expected %0d, actual %0d",
                     test_name, exp_count, got);
            mismatch_cnt++;
        end
    endtask

    // ======================================================================
    // Compare on every pooling transfer
    // ======================================================================

    always @(posedge clk) begin
        if (rst_n) begin
            // Full FIFO must hold off the global buffer
            if (fill >= DEPTH && glb_fm_ready) begin
                $display("ERROR %s: glb_fm_ready high with %0d words in the FIFO",
                         test_name, fill);
                fail_cnt++;
            end
            if (glb_fm_valid && glb_fm_ready) fill++;
            if (pool_fm_valid && pool_fm_ready) begin
                fill--;
                if (!job_open || got >= exp_count) begin
                    $display("ERROR %s: extra word 0x%08h on the pooling channel",
                             test_name, pool_fm);
                    fail_cnt++;
                end else begin
                    // k-th word comes from base + k*stride, wrapped at 16 bits
                    exp_addr = exp_base + got * exp_stride;
                    exp_word = glb_word(exp_addr);
                    if (pool_fm !== exp_word) begin
                        $display("MISMATCH %s word %0d: expected 0x%08h, actual 0x%08h",
                                 test_name, got, exp_word, pool_fm);
                        mismatch_cnt++;
                    end
                    got = got + 16'd1;
                end
            end
            if (fill > max_fill) max_fill = fill;
        end
    end

endmodule

/* dv/pool_mif_tb.sv */
/*
 * Testbench for the feature-map memory interface top.
 * Global buffer is a behavioral model that answers in address order.
 * Stalls come from a 16-bit Fibonacci LFSR with seed 32675.
 */

`timescale 1ns/1ps

module pool_mif_tb;

    import mif_types_pkg::*;
    import mif_regs_pkg::*;

    localparam int FIFO_ADDR_WIDTH = 6;
    localparam int DEPTH           = 1 << FIFO_ADDR_WIDTH;

    logic        clk            = 1'b0;
    logic        rst_n          = 1'b0;
    logic        psel           = 1'b0;
    logic        penable        = 1'b0;
    logic        pwrite         = 1'b0;
    apb_addr_t   paddr          = '0;
    logic [31:0] pwdata         = '0;
    logic [31:0] prdata;
    logic        pready;
    logic        glb_addr_valid;
    glb_addr_t   glb_addr;
    logic        glb_addr_ready = 1'b0;
    logic        glb_fm_valid   = 1'b0;
    fmap_t       glb_fm         = '0;
    logic        glb_fm_ready;
    logic        pool_fm_valid;
    fmap_t       pool_fm;
    logic        pool_fm_ready  = 1'b0;

    // Global-buffer model and stall control
    glb_addr_t   rd_q[$];
    logic [15:0] lfsr       = 16'd32675;
    logic        fm_taken   = 1'b0;
    logic        addr_stall = 1'b0;
    logic        fm_stall   = 1'b0;
    logic        pool_stall = 1'b0;
    int          pool_hold  = 0;
    int          addr_seen  = 0;
    int          err_cnt    = 0;

    always #2 clk = ~clk;

    pool_mif_top #(.FIFO_ADDR_WIDTH(FIFO_ADDR_WIDTH)) pool_mif_top_inst (.*);

    pool_mif_checker #(.FIFO_ADDR_WIDTH(FIFO_ADDR_WIDTH)) chk_inst (
        .clk           (clk),
        .rst_n         (rst_n),
        .glb_fm_valid  (glb_fm_valid),
        .glb_fm_ready  (glb_fm_ready),
        .pool_fm_valid (pool_fm_valid),
        .pool_fm       (pool_fm),
        .pool_fm_ready (pool_fm_ready)
    );

    // x^16 + x^14 + x^13 + x^11 + 1
    function automatic logic [15:0] lfsr_step(input logic [15:0] s);
        return {s[14:0], s[15] ^ s[13] ^ s[12] ^ s[10]};
    endfunction

    // ======================================================================
    // Global-buffer model
    // ======================================================================

    // Record transfers at the edge
    always @(posedge clk) begin
        if (rst_n) begin
            if (glb_addr_valid && glb_addr_ready) begin
                rd_q.push_back(glb_addr);
                addr_seen++;
            end
            if (glb_fm_valid && glb_fm_ready) begin
                void'(rd_q.pop_front());
                fm_taken = 1'b1;
            end
        end
    end

    // New channel values on the falling edge
    always @(negedge clk) begin
        if (addr_stall) begin
            lfsr = lfsr_step(lfsr);
            glb_addr_ready = lfsr[0];
        end else begin
            glb_addr_ready = 1'b1;
        end
        // Offered word stays until taken
        if (fm_taken || !glb_fm_valid) begin
            glb_fm_valid = 1'b0;
            if (rd_q.size() > 0) begin
                if (fm_stall) lfsr = lfsr_step(lfsr);
                glb_fm_valid = !fm_stall || lfsr[0];
                glb_fm = chk_inst.glb_word(rd_q[0]);
            end
        end
        fm_taken = 1'b0;
        if (pool_hold > 0) begin
            pool_fm_ready = 1'b0;
            pool_hold--;
        end else if (pool_stall) begin
            lfsr = lfsr_step(lfsr);
            pool_fm_ready = lfsr[0];
        end else begin
            pool_fm_ready = 1'b1;
        end
    end

    // ======================================================================
    // APB and job tasks entered and left on a falling edge
    // ======================================================================

    task automatic apb_access(input logic wr, input apb_addr_t addr,
                              input logic [31:0] wdata, output logic [31:0] rdata);
        int waited;
        waited  = 0;
        psel    = 1'b1;
        penable = 1'b0;
        pwrite  = wr;
        paddr   = addr;
        pwdata  = wdata;
        @(negedge clk);
        penable = 1'b1;
        @(posedge clk);
        while (!pready && waited < 16) begin
            @(posedge clk);
            waited++;
        end
        if (!pready) begin
            $display("ERROR: APB access to 0x%02h never saw pready", addr);
            err_cnt++;
        end
        rdata = prdata;
        @(negedge clk);
        psel    = 1'b0;
        penable = 1'b0;
        pwrite  = 1'b0;
    endtask

    task automatic apb_write(input apb_addr_t addr, input logic [31:0] data);
        logic [31:0] unused;
        apb_access(1'b1, addr, data, unused);
    endtask

    task automatic check_reg(input string name, input apb_addr_t addr, input logic [31:0] exp);
        logic [31:0] act;
        apb_access(1'b0, addr, 32'h0, act);
        if (act !== exp) begin
            $display("MISMATCH %s reg 0x%02h: expected 0x%08h, actual 0x%08h",
                     name, addr, exp, act);
            err_cnt++;
        end
    endtask

    task automatic check_addr_count(input string name, input word_cnt_t count);
        if (addr_seen != int'(count)) begin
            $display("MISMATCH %s address count: expected %0d, actual %0d",
                     name, count, addr_seen);
            err_cnt++;
        end
    endtask

    task automatic wait_done(input string name);
        logic [31:0] st;
        int          polls;
        st    = '0;
        polls = 0;
        while (!st[STATUS_DONE_BIT] && polls < 2000) begin
            apb_access(1'b0, REG_STATUS, 32'h0, st);
            polls++;
        end
        if (!st[STATUS_DONE_BIT]) begin
            $display("ERROR %s: job did not report done in %0d polls", name, polls);
            err_cnt++;
        end
    endtask

    task automatic setup_job(input string name, input glb_addr_t base,
                             input word_cnt_t stride, input word_cnt_t count);
        chk_inst.start_job(name, base, stride, count);
        addr_seen = 0;
        apb_write(REG_BASE, {16'h0000, base});
        apb_write(REG_COUNT, {16'h0000, count});
        apb_write(REG_STRIDE, {16'h0000, stride});
        apb_write(REG_CTRL, 32'd1 << CTRL_START_BIT);
    endtask

    task automatic finish_job(input string name, input word_cnt_t count);
        wait_done(name);
        // Done set and busy clear
        check_reg(name, REG_STATUS, 32'd1 << STATUS_DONE_BIT);
        // Window for stray words
        repeat (20) @(negedge clk);
        check_addr_count(name, count);
        chk_inst.end_job();
    endtask

    // ======================================================================
    // Stimulus
    // ======================================================================

    initial begin : main
        repeat (16) @(negedge clk);
        rst_n = 1'b1;
        repeat (2) @(negedge clk);

        // Register access with a dropped STATUS write
        check_reg("reg_access", REG_STATUS, 32'h0);
        apb_write(REG_BASE, 32'h0000_1234);
        apb_write(REG_COUNT, 32'h0000_0040);
        apb_write(REG_STRIDE, 32'h0000_0003);
        apb_write(REG_STATUS, 32'h0000_0003);
        check_reg("reg_access", REG_BASE, 32'h0000_1234);
        check_reg("reg_access", REG_COUNT, 32'h0000_0040);
        check_reg("reg_access", REG_STRIDE, 32'h0000_0003);
        check_reg("reg_access", REG_STATUS, 32'h0);
        check_reg("reg_access", REG_CTRL, 32'h0);

        setup_job("unit_stride", 16'h0100, 16'd1, 16'd24);
        finish_job("unit_stride", 16'd24);

        // Addresses cross 0xFFFF
        setup_job("stride_wrap", 16'hFFF0, 16'd37, 16'd40);
        finish_job("stride_wrap", 16'd40);

        // Pooling side blocked first so the FIFO fills up
        @(posedge clk);
        addr_stall = 1'b1;
        fm_stall   = 1'b1;
        pool_stall = 1'b1;
        pool_hold  = 300;
        @(negedge clk);
        setup_job("random_stall", 16'h2345, 16'd5, 16'd150);
        finish_job("random_stall", 16'd150);
        if (chk_inst.max_fill != DEPTH) begin
            $display("ERROR random_stall: FIFO peaked at %0d words, never full",
                     chk_inst.max_fill);
            err_cnt++;
        end

        // Busy during a job and the starts that must be dropped
        @(posedge clk);
        addr_stall = 1'b0;
        fm_stall   = 1'b0;
        pool_stall = 1'b0;
        pool_hold  = 40;
        @(negedge clk);
        setup_job("status", 16'h0800, 16'd2, 16'd32);
        check_reg("status_busy", REG_STATUS, 32'd1 << STATUS_BUSY_BIT);
        apb_write(REG_CTRL, 32'd1 << CTRL_START_BIT);
        finish_job("status", 16'd32);
        apb_write(REG_COUNT, 32'h0);
        apb_write(REG_CTRL, 32'd1 << CTRL_START_BIT);
        repeat (20) @(negedge clk);
        check_reg("status_zero_count", REG_STATUS, 32'd1 << STATUS_DONE_BIT);
        check_addr_count("status_zero_count", 16'd32);
        chk_inst.end_job();

        $display("Error counts: %0d mismatches, %0d checker errors, %0d testbench errors",
                 chk_inst.mismatch_cnt, chk_inst.fail_cnt, err_cnt);
        if (chk_inst.mismatch_cnt == 0 && chk_inst.fail_cnt == 0 && err_cnt == 0) begin
            $display("Testbench passed");
        end else begin
            $display("Testbench failed");
        end
        $finish;
    end

    // Hard limit on the whole run
    initial begin : watchdog
        int cycles;
        cycles = 0;
        while (cycles < 100000) begin
            @(posedge clk);
            cycles++;
        end
        $display("ERROR: simulation ran past %0d cycles", cycles);
        $display("Error counts: %0d mismatches, %0d checker errors, %0d testbench errors",
                 chk_inst.mismatch_cnt, chk_inst.fail_cnt, err_cnt);
        $display("Testbench failed");
        $finish;
    end

endmodule

/* pool_mif.f */
source/mif_types_pkg.sv
source/mif_regs_pkg.sv
source/mif_cfg_if.sv
source/mif_apb_regs.sv
source/mif_addr_gen.sv
source/mif_fmap_fifo.sv
source/pool_mif_top.sv
dv/pool_mif_checker.sv
dv/pool_mif_tb.sv

/* source/mif_addr_gen.sv */
/*
 * Job controller. Issues count strided word addresses to the global buffer
 * and ends the job when the last word has left toward the pooling unit.
 * Addresses wrap at 16 bits. Returned data must arrive in address order.
 */

`timescale 1ns/1ps

module mif_addr_gen (
    input  logic                    clk,
    input  logic                    rst_n,
    mif_cfg_if.ctrl                 cfg,
    output logic                    glb_addr_valid,
    output mif_types_pkg::glb_addr_t glb_addr,
    input  logic                    glb_addr_ready,
    input  logic                    pool_pop
);

    import mif_regs_pkg::*;
    import mif_types_pkg::*;

    // ======================================================================
    // Declarations
    // ======================================================================

    mif_state_e state_q;
    mif_state_e state_d;

    // Job parameters latched at start
    glb_addr_t  addr_q;
    word_cnt_t  stride_q;
    word_cnt_t  count_q;

    // Progress counters
    word_cnt_t  issued_q;
    word_cnt_t  popped_q;

    logic       done_q;

    logic       addr_xfer;
    logic       last_issue;
    logic       last_pop;

    // Handshake and end-of-job conditions
    assign addr_xfer  = glb_addr_valid && glb_addr_ready;
    assign last_issue = addr_xfer && (issued_q == count_q - 16'd1);
    assign last_pop   = pool_pop && (popped_q == count_q - 16'd1);

    // ======================================================================
    // FSM
    // ======================================================================

    always_comb begin
        state_d = state_q;
        case (state_q)
            IDLE:    if (cfg.start) state_d = ISSUE;
            // All addresses out, wait for the data
            ISSUE:   if (last_issue) state_d = DRAIN;
            DRAIN:   if (last_pop) state_d = IDLE;
            default: state_d = IDLE;
        endcase
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            state_q <= IDLE;
        end else begin
            state_q <= state_d;
        end
    end

    // ======================================================================
    // Address and progress tracking
    // ======================================================================

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            addr_q   <= '0;
            stride_q <= '0;
            count_q  <= '0;
            issued_q <= '0;
            popped_q <= '0;
            done_q   <= 1'b0;
        end else begin
            if (state_q == IDLE && cfg.start) begin
                addr_q   <= cfg.base;
                stride_q <= cfg.stride;
                count_q  <= cfg.count;
                issued_q <= '0;
                popped_q <= '0;
                done_q   <= 1'b0;
            end else begin
                // Next address, wraps naturally at 16 bits
                if (addr_xfer) begin
                    addr_q   <= addr_q + stride_q;
                    issued_q <= issued_q + 16'd1;
                end
                if (pool_pop && state_q != IDLE) begin
                    popped_q <= popped_q + 16'd1;
                end
                if (state_q == DRAIN && last_pop) done_q <= 1'b1;
            end
        end
    end

    // Address held stable until accepted
    assign glb_addr_valid = (state_q == ISSUE);
    assign glb_addr       = addr_q;

    // Status
    assign cfg.busy = (state_q != IDLE);
    assign cfg.done = done_q;

endmodule

/* source/mif_apb_regs.sv */
/*
 * APB slave for job setup. No wait states and no error responses.
 * Writes to STATUS or unmapped offsets are dropped, unmapped reads return zero.
 * A start with zero count or while a job runs is dropped.
 */

`timescale 1ns/1ps

module mif_apb_regs (
    input  logic                  clk,
    input  logic                  rst_n,
    input  logic                  psel,
    input  logic                  penable,
    input  logic                  pwrite,
    input  mif_regs_pkg::apb_addr_t paddr,
    input  logic [31:0]           pwdata,
    output logic [31:0]           prdata,
    output logic                  pready,
    mif_cfg_if.regs               cfg
);

    import mif_regs_pkg::*;
    import mif_types_pkg::*;

    // ======================================================================
    // Declarations
    // ======================================================================

    glb_addr_t base_q;
    word_cnt_t count_q;
    word_cnt_t stride_q;
    logic      start_q;

    logic      wr_en;
    logic      start_req;

    // Always ready, single access phase
    assign pready = 1'b1;

    // Write lands on the edge closing the access phase
    assign wr_en = psel && penable && pwrite;

    // Start request, qualified against a running job and an empty job
    assign start_req = wr_en && (paddr == REG_CTRL) && pwdata[CTRL_START_BIT]
                       && !cfg.busy && !start_q && (count_q != '0);

    // ======================================================================
    // Register writes
    // ======================================================================

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            base_q   <= '0;
            count_q  <= '0;
            stride_q <= '0;
            start_q  <= 1'b0;
        end else begin
            // Pulse shows up the cycle after the CTRL write
            start_q <= start_req;
            if (wr_en) begin
                case (paddr)
                    REG_BASE:   base_q   <= pwdata[GLB_ADDR_W-1:0];
                    REG_COUNT:  count_q  <= pwdata[WORD_CNT_W-1:0];
                    REG_STRIDE: stride_q <= pwdata[WORD_CNT_W-1:0];
                    // CTRL handled by start_req, STATUS read-only
                    default: ;
                endcase
            end
        end
    end

    // ======================================================================
    // Read mux
    // ======================================================================

    // Valid through the access phase, upper bits zero
    always_comb begin
        prdata = '0;
        case (paddr)
            REG_STATUS: begin
                prdata[STATUS_BUSY_BIT] = cfg.busy;
                prdata[STATUS_DONE_BIT] = cfg.done;
            end
            REG_BASE:   prdata[GLB_ADDR_W-1:0] = base_q;
            REG_COUNT:  prdata[WORD_CNT_W-1:0] = count_q;
            REG_STRIDE: prdata[WORD_CNT_W-1:0] = stride_q;
            // CTRL and unmapped offsets read zero
            default:    prdata = '0;
        endcase
    end

    // To the controller
    assign cfg.base   = base_q;
    assign cfg.count  = count_q;
    assign cfg.stride = stride_q;
    assign cfg.start  = start_q;

endmodule

/* source/mif_cfg_if.sv */
/*
 * Job configuration between the register block and the address controller.
 * start is a single-cycle pulse; base, count and stride are only sampled on it.
 */

`timescale 1ns/1ps

interface mif_cfg_if;

    import mif_types_pkg::*;

    // Job setup, held by the register block
    glb_addr_t base;
    word_cnt_t count;
    word_cnt_t stride;

    // One-cycle request to begin a job
    logic      start;

    // Job status from the controller
    logic      busy;
    logic      done;

    // Register side
    modport regs (
        output base,
        output count,
        output stride,
        output start,
        input  busy,
        input  done
    );

    // Controller side
    modport ctrl (
        input  base,
        input  count,
        input  stride,
        input  start,
        output busy,
        output done
    );

endinterface

/* source/mif_fmap_fifo.sv */
/*
 * Synchronous FIFO for feature words, depth 2**FIFO_ADDR_WIDTH.
 * Output word is read combinationally from the head entry.
 * Push while full and pop while empty are dropped.
 */

`timescale 1ns/1ps

module mif_fmap_fifo #(
    parameter int FIFO_ADDR_WIDTH = 6
) (
    input  logic                 clk,
    input  logic                 rst_n,
    input  logic                 push,
    input  mif_types_pkg::fmap_t data_in,
    output logic                 full,
    input  logic                 pop,
    output mif_types_pkg::fmap_t data_out,
    output logic                 empty
);

    import mif_types_pkg::*;

    localparam int DEPTH = 1 << FIFO_ADDR_WIDTH;

    // ======================================================================
    // Storage and pointers
    // ======================================================================

    fmap_t                    mem [DEPTH];

    logic [FIFO_ADDR_WIDTH-1:0] wr_ptr;
    logic [FIFO_ADDR_WIDTH-1:0] rd_ptr;
    // One extra bit to tell full from empty
    logic [FIFO_ADDR_WIDTH:0]   fill;

    logic do_push;
    logic do_pop;

    assign do_push = push && !full;
    assign do_pop  = pop && !empty;

    // Payload only, no reset
    always_ff @(posedge clk) begin
        if (do_push) mem[wr_ptr] <= data_in;
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            fill   <= '0;
        end else begin
            // Pointers wrap at the depth
            if (do_push) wr_ptr <= wr_ptr + 1'b1;
            if (do_pop)  rd_ptr <= rd_ptr + 1'b1;
            // Simultaneous push and pop keeps the level
            case ({do_push, do_pop})
                2'b10:   fill <= fill + 1'b1;
                2'b01:   fill <= fill - 1'b1;
                default: fill <= fill;
            endcase
        end
    end

    // ======================================================================
    // Status and head word
    // ======================================================================

    assign full     = (fill == DEPTH[FIFO_ADDR_WIDTH:0]);
    assign empty    = (fill == '0);
    assign data_out = mem[rd_ptr];

endmodule

/* source/mif_regs_pkg.sv */
/*
 * APB register map and controller states of the feature-map memory interface.
 * Offsets are byte addresses on an 8-bit APB address bus, all registers 32 bits wide.
 */

package mif_regs_pkg;

    // ======================================================================
    // Register map
    // ======================================================================

    typedef logic [7:0] apb_addr_t;

    localparam apb_addr_t REG_CTRL   = 8'h00;
    localparam apb_addr_t REG_STATUS = 8'h04;
    localparam apb_addr_t REG_BASE   = 8'h08;
    localparam apb_addr_t REG_COUNT  = 8'h0C;
    localparam apb_addr_t REG_STRIDE = 8'h10;

    // CTRL is write-only, reads as zero
    localparam int CTRL_START_BIT  = 0;

    // STATUS is read-only
    localparam int STATUS_BUSY_BIT = 0;
    localparam int STATUS_DONE_BIT = 1;

    // ======================================================================
    // Controller states
    // ======================================================================

    typedef enum logic [1:0] {
        IDLE  = 2'd0,
        ISSUE = 2'd1,
        DRAIN = 2'd2
    } mif_state_e;

endpackage

/* source/mif_types_pkg.sv */
/*
 * Data-path types of the feature-map memory interface.
 * Widths are fixed by the global buffer and pooling unit and are not module parameters.
 * Global-buffer addresses count words, not bytes.
 */

package mif_types_pkg;

    // ======================================================================
    // Widths
    // ======================================================================

    // Word address into the global buffer
    localparam int GLB_ADDR_W = 16;

    // One feature-map word as seen by the pooling unit
    localparam int FMAP_W     = 32;

    // Job word count and address stride
    localparam int WORD_CNT_W = 16;

    // ======================================================================
    // Types
    // ======================================================================

    typedef logic [GLB_ADDR_W-1:0] glb_addr_t;
    typedef logic [FMAP_W-1:0]     fmap_t;
    // Also used for the stride, same width as an address
    typedef logic [WORD_CNT_W-1:0] word_cnt_t;

endpackage

/* source/pool_mif_top.sv */
/*
 * Feature-map memory interface top. APB setup, global-buffer read channels
 * and a valid/ready stream to the pooling unit. One job at a time.
 * The global buffer must return data in the order the addresses were accepted.
 */

`timescale 1ns/1ps

module pool_mif_top #(
    parameter int FIFO_ADDR_WIDTH = 6
) (
    input  logic                     clk,
    input  logic                     rst_n,

    // APB configuration port
    input  logic                     psel,
    input  logic                     penable,
    input  logic                     pwrite,
    input  mif_regs_pkg::apb_addr_t  paddr,
    input  logic [31:0]              pwdata,
    output logic [31:0]              prdata,
    output logic                     pready,

    // Global-buffer address channel
    output logic                     glb_addr_valid,
    output mif_types_pkg::glb_addr_t glb_addr,
    input  logic                     glb_addr_ready,

    // Global-buffer data channel
    input  logic                     glb_fm_valid,
    input  mif_types_pkg::fmap_t     glb_fm,
    output logic                     glb_fm_ready,

    // Pooling unit stream
    output logic                     pool_fm_valid,
    output mif_types_pkg::fmap_t     pool_fm,
    input  logic                     pool_fm_ready
);

    // ======================================================================
    // Glue
    // ======================================================================

    logic fifo_push;
    logic fifo_pop;
    logic fifo_full;
    logic fifo_empty;

    mif_cfg_if cfg_if ();

    // Accept returned words while there is room
    assign glb_fm_ready  = !fifo_full;
    assign fifo_push     = glb_fm_valid && !fifo_full;

    // Head word goes out as soon as it exists
    assign pool_fm_valid = !fifo_empty;
    // Also counts delivered words in the controller
    assign fifo_pop      = pool_fm_valid && pool_fm_ready;

    // ======================================================================
    // Blocks
    // ======================================================================

    mif_apb_regs u_apb_regs (
        .clk     (clk),
        .rst_n   (rst_n),
        .psel    (psel),
        .penable (penable),
        .pwrite  (pwrite),
        .paddr   (paddr),
        .pwdata  (pwdata),
        .prdata  (prdata),
        .pready  (pready),
        .cfg     (cfg_if.regs)
    );

    mif_addr_gen u_addr_gen (
        .clk            (clk),
        .rst_n          (rst_n),
        .cfg            (cfg_if.ctrl),
        .glb_addr_valid (glb_addr_valid),
        .glb_addr       (glb_addr),
        .glb_addr_ready (glb_addr_ready),
        .pool_pop       (fifo_pop)
    );

    mif_fmap_fifo #(
        .FIFO_ADDR_WIDTH (FIFO_ADDR_WIDTH)
    ) u_fmap_fifo (
        .clk      (clk),
        .rst_n    (rst_n),
        .push     (fifo_push),
        .data_in  (glb_fm),
        .full     (fifo_full),
        .pop      (fifo_pop),
        .data_out (pool_fm),
        .empty    (fifo_empty)
    );

endmodule
